// File: bench/ldu_addr_pipeline_sva.sv
`timescale 1ns/100ps

module ldu_addr_pipeline_sva import ldu_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        issue_ready,
    input  logic        req_bank0_valid,
    input  logic        req_bank1_valid,
    input  ldu_req_t    req,
    input  logic        bank0_early_ready,
    input  logic        bank1_early_ready
);

    int failures = 0;

    logic req_valid;
    logic accepted;

    assign req_valid = req_bank0_valid | req_bank1_valid;
    assign accepted = req_valid & bank0_early_ready & bank1_early_ready;

    // ------------------------------------------------------------
    // reset

    quiet_in_reset: assert property (@(posedge CLK) !nRST |-> !req_valid)
        else begin
            $error("bank valid high during reset");
            failures++;
        end

    ready_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> !req_valid && issue_ready)
        else begin
            $error("issue_ready low or bank valid high as reset ends");
            failures++;
        end

    quiet_after_reset: assert property (@(posedge CLK) $rose(nRST) |=> !req_valid)
        else begin
            $error("bank valid high in the cycle after reset");
            failures++;
        end

    // ------------------------------------------------------------
    // request channel

    // stalled request holds until both banks are early-ready
    held_under_stall: assert property (@(posedge CLK) disable iff (!nRST)
        req_valid && !accepted |=> req_valid && $stable(req)
            && $stable(req_bank0_valid) && $stable(req_bank1_valid))
        else begin
            $error("request changed while stalled");
            failures++;
        end

    one_bank_only: assert property (@(posedge CLK) disable iff (!nRST)
        !(req_bank0_valid && req_bank1_valid))
        else begin
            $error("both bank valids high together");
            failures++;
        end

    bank_follows_word: assert property (@(posedge CLK) disable iff (!nRST)
        req_valid |-> req_bank1_valid == req.po_word[DCACHE_WORD_ADDR_BANK_BIT])
        else begin
            $error("bank valid does not follow the page-offset word");
            failures++;
        end

endmodule

// File: bench/ldu_addr_pipeline_tb.sv
`timescale 1ns/100ps

module ldu_addr_pipeline_tb import ldu_pkg::*; ();

    localparam int LOADS_PER_TEST = 40;
    localparam int TEST_COUNT = 5;
    localparam int CYCLE_LIMIT = TEST_COUNT * LOADS_PER_TEST * 25 + 200;

    logic                                       CLK;
    logic                                       nRST;
    logic                                       issue_valid;
    ldu_issue_t                                 issue;
    operand_src_t                               issue_src;
    logic                                       issue_ready;
    logic                                       reg_read_resp_valid;
    logic [31:0]                                reg_read_resp_data;
    logic [PRF_BANK_COUNT-1:0][31:0]            bus_forward_data_by_bank;
    logic [FAST_FORWARD_PIPE_COUNT-1:0]         fast_forward_data_valid_by_pipe;
    logic [FAST_FORWARD_PIPE_COUNT-1:0][31:0]   fast_forward_data_by_pipe;
    logic                                       req_bank0_valid;
    logic                                       req_bank1_valid;
    ldu_req_t                                   req;
    logic                                       bank0_early_ready;
    logic                                       bank1_early_ready;

    ldu_req_t                       expected_q [$];
    ldu_op_t                        ops [5] = '{LB, LH, LW, LBU, LHU};
    logic [LOG_LDU_CQ_ENTRIES-1:0]  next_cq;
    int errors = 0;
    int checked = 0;
    int retries = 0;
    int cycles = 0;
    int bp_mode = 0;
    int phase_left = 0;
    logic phase_stall = 1'b0;
    logic stall_bank = 1'b0;
    logic second_due = 1'b0;

    ldu_addr_pipeline dut0 (.*);

    bind ldu_addr_pipeline ldu_addr_pipeline_sva sva0 (
        .CLK(CLK),
        .nRST(nRST),
        .issue_ready(issue_ready),
        .req_bank0_valid(req_bank0_valid),
        .req_bank1_valid(req_bank1_valid),
        .req(req),
        .bank0_early_ready(bank0_early_ready),
        .bank1_early_ready(bank1_early_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // bank back-pressure where mode 0 is none, 1 random and 2 long stalls

    always @(negedge CLK) begin
        if (bp_mode == 1) begin
            bank0_early_ready = ($urandom % 4) != 0;
            bank1_early_ready = ($urandom % 4) != 0;
        end
        else if (bp_mode == 2) begin
            if (phase_left == 0) begin
                phase_stall = ~phase_stall;
                phase_left = phase_stall ? 8 + $urandom % 13 : 2 + $urandom % 5;
                stall_bank = 1'($urandom % 2);
            end
            phase_left--;
            bank0_early_ready = !(phase_stall && !stall_bank);
            bank1_early_ready = !(phase_stall && stall_bank);
        end
        else begin
            bank0_early_ready = 1'b1;
            bank1_early_ready = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // reference model

    task automatic check_field(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic push_expected(input ldu_op_t op, input logic [11:0] imm12,
            input logic [31:0] base, input logic [LOG_LDU_CQ_ENTRIES-1:0] cq);
        logic [31:0] va;
        logic [31:0] next_va;
        logic [7:0] size_mask;
        logic [7:0] span;
        ldu_req_t r;
        va = base + 32'($signed(imm12));
        size_mask = op[1] ? 8'h0f : (op[0] ? 8'h03 : 8'h01);
        // upper nibble holds bytes spilling into the next word
        span = size_mask << va[1:0];
        r.is_mq = 1'b0;
        r.misaligned = (span[7:4] != 4'h0);
        r.vpn = va[31:PO_WIDTH];
        r.po_word = va[PO_WIDTH-1:2];
        r.byte_mask = span[3:0];
        r.cq_index = cq;
        expected_q.push_back(r);
        if (r.misaligned) begin
            next_va = va + 32'h4;
            r.is_mq = 1'b1;
            r.vpn = next_va[31:PO_WIDTH];
            r.po_word = next_va[PO_WIDTH-1:2];
            r.byte_mask = span[7:4];
            expected_q.push_back(r);
        end
    endtask

    // compare every accepted request with the model head
    always @(posedge CLK) begin
        ldu_req_t exp;
        if (nRST) begin
            if (second_due) begin
                assert (req_bank0_valid || req_bank1_valid) else begin
                    $display("second access of a misaligned load did not follow the first");
                    errors++;
                end
            end
            second_due = 1'b0;
            if ((req_bank0_valid || req_bank1_valid) && bank0_early_ready
                    && bank1_early_ready) begin
                if (expected_q.size() == 0) begin
                    $display("request accepted with no load outstanding");
                    errors++;
                end
                else begin
                    exp = expected_q.pop_front();
                    check_field("req.is_mq", 32'(req.is_mq), 32'(exp.is_mq));
                    check_field("req.misaligned", 32'(req.misaligned), 32'(exp.misaligned));
                    check_field("req.vpn", 32'(req.vpn), 32'(exp.vpn));
                    check_field("req.po_word", 32'(req.po_word), 32'(exp.po_word));
                    check_field("req.byte_mask", 32'(req.byte_mask), 32'(exp.byte_mask));
                    check_field("req.cq_index", 32'(req.cq_index), 32'(exp.cq_index));
                    check_field("req_bank0_valid", 32'(req_bank0_valid),
                        32'(!exp.po_word[DCACHE_WORD_ADDR_BANK_BIT]));
                    check_field("req_bank1_valid", 32'(req_bank1_valid),
                        32'(exp.po_word[DCACHE_WORD_ADDR_BANK_BIT]));
                    second_due = exp.misaligned && !exp.is_mq;
                    checked++;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus

    // src_kind 0 register, 1 bus forward, 2 fast forward
    task automatic issue_load(input ldu_op_t op, input logic [11:0] imm12,
            input logic [31:0] base, input int src_kind);
        operand_src_t src;
        logic accepted;
        int delay;
        src = '0;
        src.is_reg = (src_kind == 0);
        src.is_bus_forward = (src_kind == 1);
        src.is_fast_forward = (src_kind == 2);
        src.fast_forward_pipe = LOG_FAST_FORWARD_PIPE_COUNT'($urandom % FAST_FORWARD_PIPE_COUNT);
        src.bank = LOG_PRF_BANK_COUNT'($urandom % PRF_BANK_COUNT);
        accepted = 1'b0;
        // offered again until issue_ready lets it in
        while (!accepted) begin
            @(negedge CLK);
            issue_valid = 1'b1;
            issue.op = op;
            issue.imm12 = imm12;
            issue.cq_index = next_cq;
            issue_src = src;
            accepted = issue_ready;
            if (accepted) begin
                push_expected(op, imm12, base, next_cq);
            end
            else begin
                retries++;
            end
            @(posedge CLK);
        end
        next_cq = next_cq + 1'b1;
        @(negedge CLK);
        issue_valid = 1'b0;
        if (src_kind == 1) begin
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                bus_forward_data_by_bank[b] = $urandom;
            end
            bus_forward_data_by_bank[src.bank] = base;
        end
        else begin
            delay = $urandom % 6;
            repeat (delay) @(negedge CLK);
            if (src_kind == 0) begin
                reg_read_resp_valid = 1'b1;
                reg_read_resp_data = base;
            end
            else begin
                fast_forward_data_valid_by_pipe[src.fast_forward_pipe] = 1'b1;
                fast_forward_data_by_pipe[src.fast_forward_pipe] = base;
            end
            @(negedge CLK);
            reg_read_resp_valid = 1'b0;
            fast_forward_data_valid_by_pipe = '0;
        end
    endtask

    // shape 0 aligned sweep, 1 forced misaligned, 2 random
    task automatic run_test(input int num, input string name, input int mode, input int shape);
        int first_errors;
        int first_checked;
        int src_kind;
        ldu_op_t op;
        logic [11:0] imm12;
        logic [31:0] base;
        logic [31:0] va;
        first_errors = errors;
        first_checked = checked;
        retries = 0;
        bp_mode = mode;
        for (int i = 0; i < LOADS_PER_TEST; i++) begin
            base = $urandom;
            imm12 = 12'($urandom);
            if (shape == 0) begin
                op = ops[i % 5];
                src_kind = (i / 5) % 3;
            end
            else begin
                op = ops[$urandom % 5];
                src_kind = $urandom % 3;
            end
            if (shape == 1 && i % 4 == 0) begin
                // last word of a page, so the second access crosses it
                imm12 = '0;
                base[PO_WIDTH-1:2] = '1;
            end
            va = base + 32'($signed(imm12));
            if (shape == 0) begin
                if (op[1]) begin
                    base = base - 32'(va[1:0]);
                end
                else if (op[0]) begin
                    base = base - 32'(va[0]);
                end
            end
            else if (shape == 1) begin
                if (op[1] && va[1:0] == 2'b00) begin
                    base = base + 32'(1 + $urandom % 3);
                end
                else if (op[0] && !op[1]) begin
                    base = base + 32'(2'b11 - va[1:0]);
                end
            end
            issue_load(op, imm12, base, src_kind);
        end
        while (expected_q.size() != 0) begin
            @(posedge CLK);
        end
        repeat (2) @(posedge CLK);
        if (mode == 2) begin
            assert (retries > 0) else begin
                $display("issue_ready never fell under held back-pressure");
                errors++;
            end
        end
        $display("test %0d %s: %0d requests, %0d retries, %0d errors", num, name,
            checked - first_checked, retries, errors - first_errors);
    endtask

    initial begin
        int total;
        void'($urandom(32'h2787));
        nRST = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        issue_src = '0;
        reg_read_resp_valid = 1'b0;
        reg_read_resp_data = '0;
        bus_forward_data_by_bank = '0;
        fast_forward_data_valid_by_pipe = '0;
        fast_forward_data_by_pipe = '0;
        bank0_early_ready = 1'b1;
        bank1_early_ready = 1'b1;
        next_cq = '0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        repeat (2) @(negedge CLK);

        run_test(1, "aligned opcodes and sources", 0, 0);
        run_test(2, "misaligned split", 0, 1);
        run_test(3, "random back-pressure", 1, 2);
        run_test(4, "held back-pressure", 2, 2);
        run_test(5, "misaligned under back-pressure", 1, 1);

        total = errors + dut0.sva0.failures;
        $display("%0d tests, %0d requests checked, %0d errors", TEST_COUNT, checked, total);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // run limit from loads times worst cycles per load
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: src.f
src/ldu_pkg.sv
src/ldu_issue_buffer.sv
src/ldu_operand_collector.sv
src/ldu_addr_gen.sv
src/ldu_req_sequencer.sv
src/ldu_addr_pipeline.sv
bench/ldu_addr_pipeline_sva.sv
bench/ldu_addr_pipeline_tb.sv

// File: src/ldu_addr_gen.sv
`timescale 1ns/100ps

module ldu_addr_gen import ldu_pkg::*; (
    input  logic [31:0] base,
    input  ldu_op_t     op,
    input  logic [11:0] imm12,
    output logic [31:0] va,
    output logic        misaligned,
    output logic [3:0]  first_mask,
    output logic [3:0]  second_mask
);

    assign va = base + {{20{imm12[11]}}, imm12};

    always_comb begin
        // word loads
        if (op[1]) begin
            misaligned = (va[1:0] != 2'b00);
            case (va[1:0])
                2'b00: begin
                    first_mask = 4'b1111;
                    second_mask = 4'b0000;
                end
                2'b01: begin
                    first_mask = 4'b1110;
                    second_mask = 4'b0001;
                end
                2'b10: begin
                    first_mask = 4'b1100;
                    second_mask = 4'b0011;
                end
                default: begin
                    first_mask = 4'b1000;
                    second_mask = 4'b0111;
                end
            endcase
        end

        // half loads where only offset 3 crosses the word
        else if (op[0]) begin
            misaligned = (va[1:0] == 2'b11);
            second_mask = 4'b0000;
            case (va[1:0])
                2'b00: first_mask = 4'b0011;
                2'b01: first_mask = 4'b0110;
                2'b10: first_mask = 4'b1100;
                default: begin
                    first_mask = 4'b1000;
                    second_mask = 4'b0001;
                end
            endcase
        end

        // byte loads never split
        else begin
            misaligned = 1'b0;
            second_mask = 4'b0000;
            case (va[1:0])
                2'b00:   first_mask = 4'b0001;
                2'b01:   first_mask = 4'b0010;
                2'b10:   first_mask = 4'b0100;
                default: first_mask = 4'b1000;
            endcase
        end
    end

endmodule

// File: src/ldu_addr_pipeline.sv
`timescale 1ns/100ps

module ldu_addr_pipeline import ldu_pkg::*; (
    input  logic                                        CLK,
    input  logic                                        nRST,

    // issue from the IQ
    input  logic                                        issue_valid,
    input  ldu_issue_t                                  issue,
    input  operand_src_t                                issue_src,
    output logic                                        issue_ready,

    // operand sources
    input  logic                                        reg_read_resp_valid,
    input  logic [31:0]                                 reg_read_resp_data,
    input  logic [PRF_BANK_COUNT-1:0][31:0]             bus_forward_data_by_bank,
    input  logic [FAST_FORWARD_PIPE_COUNT-1:0]          fast_forward_data_valid_by_pipe,
    input  logic [FAST_FORWARD_PIPE_COUNT-1:0][31:0]    fast_forward_data_by_pipe,

    // dcache bank requests
    output logic                                        req_bank0_valid,
    output logic                                        req_bank1_valid,
    output ldu_req_t                                    req,
    input  logic                                        bank0_early_ready,
    input  logic                                        bank1_early_ready
);

    logic           oc_valid;
    ldu_issue_t     oc_issue;
    logic           operand_collected;
    logic [31:0]    operand_data;
    logic           advance;

    ldu_issue_buffer issue_buffer0 (
        .CLK(CLK),
        .nRST(nRST),
        .enq_valid(issue_valid),
        .enq_data(issue),
        .enq_ready(issue_ready),
        .deq_valid(oc_valid),
        .deq_data(oc_issue),
        .deq_ready(advance & operand_collected)
    );

    ldu_operand_collector operand_collector0 (
        .CLK(CLK),
        .nRST(nRST),
        .enq_valid(issue_valid & issue_ready),
        .enq_src(issue_src),
        .reg_read_resp_valid(reg_read_resp_valid),
        .reg_read_resp_data(reg_read_resp_data),
        .bus_forward_data_by_bank(bus_forward_data_by_bank),
        .fast_forward_data_valid_by_pipe(fast_forward_data_valid_by_pipe),
        .fast_forward_data_by_pipe(fast_forward_data_by_pipe),
        .operand_collected(operand_collected),
        .operand_data(operand_data),
        .advance(advance)
    );

    ldu_req_sequencer req_sequencer0 (
        .CLK(CLK),
        .nRST(nRST),
        .head_valid(oc_valid),
        .head_issue(oc_issue),
        .operand_collected(operand_collected),
        .operand_data(operand_data),
        .bank0_early_ready(bank0_early_ready),
        .bank1_early_ready(bank1_early_ready),
        .advance(advance),
        .req_bank0_valid(req_bank0_valid),
        .req_bank1_valid(req_bank1_valid),
        .req(req)
    );

endmodule

// File: src/ldu_issue_buffer.sv
`timescale 1ns/100ps

module ldu_issue_buffer import ldu_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    input  logic        enq_valid,
    input  ldu_issue_t  enq_data,
    output logic        enq_ready,

    output logic        deq_valid,
    output ldu_issue_t  deq_data,
    input  logic        deq_ready
);

    ldu_issue_t entries [IS_OC_BUFFER_SIZE];

    logic [LOG_IS_OC_BUFFER_SIZE-1:0]   rd_ptr;
    logic [LOG_IS_OC_BUFFER_SIZE-1:0]   wr_ptr;
    logic [LOG_IS_OC_BUFFER_SIZE:0]     count;

    logic enq_fire;
    logic deq_fire;

    // ready depends on occupancy only and never on deq_ready
    assign enq_ready = (count < IS_OC_BUFFER_SIZE);
    assign deq_valid = (count != '0);
    assign deq_data = entries[rd_ptr];

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else begin
            if (enq_fire) begin
                wr_ptr <= (wr_ptr == IS_OC_BUFFER_SIZE - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= (rd_ptr == IS_OC_BUFFER_SIZE - 1) ? '0 : rd_ptr + 1'b1;
            end

            case ({enq_fire, deq_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            entries[wr_ptr] <= enq_data;
        end
    end

endmodule

// File: src/ldu_operand_collector.sv
`timescale 1ns/100ps

module ldu_operand_collector import ldu_pkg::*; (
    input  logic                                        CLK,
    input  logic                                        nRST,

    input  logic                                        enq_valid,
    input  operand_src_t                                enq_src,

    input  logic                                        reg_read_resp_valid,
    input  logic [31:0]                                 reg_read_resp_data,
    input  logic [PRF_BANK_COUNT-1:0][31:0]             bus_forward_data_by_bank,
    input  logic [FAST_FORWARD_PIPE_COUNT-1:0]          fast_forward_data_valid_by_pipe,
    input  logic [FAST_FORWARD_PIPE_COUNT-1:0][31:0]    fast_forward_data_by_pipe,

    output logic                                        operand_collected,
    output logic [31:0]                                 operand_data,
    input  logic                                        advance
);

    logic [OC_ENTRIES-1:0]      slot_valid;
    logic [OC_ENTRIES-1:0]      slot_collected;
    operand_src_t               slot_src [OC_ENTRIES];
    logic [31:0]                slot_data [OC_ENTRIES];
    logic [LOG_OC_ENTRIES-1:0]  head;
    logic [LOG_OC_ENTRIES-1:0]  tail;

    // bus forward lands one cycle after issue
    logic                       bf_valid;
    logic [LOG_OC_ENTRIES-1:0]  bf_slot;

    operand_src_t               cur_src [OC_ENTRIES];
    logic [OC_ENTRIES-1:0]      pending;
    logic [OC_ENTRIES-1:0]      fill;
    logic [31:0]                fill_data [OC_ENTRIES];

    // ------------------------------------------------------------
    // fill selection

    always_comb begin
        logic [LOG_OC_ENTRIES-1:0] idx;
        logic reg_taken;

        for (int i = 0; i < OC_ENTRIES; i++) begin
            cur_src[i] = slot_src[i];
            pending[i] = slot_valid[i] & ~slot_collected[i];
            fill[i] = 1'b0;
            fill_data[i] = '0;
            // slot written this cycle can already catch data
            if (enq_valid && tail == LOG_OC_ENTRIES'(i)) begin
                cur_src[i] = enq_src;
                pending[i] = 1'b1;
            end
        end

        // walk oldest to youngest so reg responses stay in order
        reg_taken = 1'b0;
        idx = head;
        for (int i = 0; i < OC_ENTRIES; i++) begin
            if (pending[idx]) begin
                if (cur_src[idx].is_reg && reg_read_resp_valid && !reg_taken) begin
                    fill[idx] = 1'b1;
                    fill_data[idx] = reg_read_resp_data;
                    reg_taken = 1'b1;
                end
                if (cur_src[idx].is_fast_forward
                        && fast_forward_data_valid_by_pipe[cur_src[idx].fast_forward_pipe]) begin
                    fill[idx] = 1'b1;
                    fill_data[idx] = fast_forward_data_by_pipe[cur_src[idx].fast_forward_pipe];
                end
            end
            idx = (idx == OC_ENTRIES - 1) ? '0 : idx + 1'b1;
        end

        if (bf_valid && slot_valid[bf_slot] && slot_src[bf_slot].is_bus_forward) begin
            fill[bf_slot] = 1'b1;
            fill_data[bf_slot] = bus_forward_data_by_bank[slot_src[bf_slot].bank];
        end
    end

    assign operand_collected = slot_valid[head] & slot_collected[head];
    assign operand_data = slot_data[head];

    // ------------------------------------------------------------
    // slot state

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head <= '0;
            tail <= '0;
            slot_valid <= '0;
            slot_collected <= '0;
            bf_valid <= 1'b0;
            bf_slot <= '0;
        end
        else begin
            bf_valid <= enq_valid & enq_src.is_bus_forward;
            bf_slot <= tail;
            if (advance) begin
                slot_valid[head] <= 1'b0;
                head <= (head == OC_ENTRIES - 1) ? '0 : head + 1'b1;
            end
            if (enq_valid) begin
                slot_valid[tail] <= 1'b1;
                slot_collected[tail] <= 1'b0;
                tail <= (tail == OC_ENTRIES - 1) ? '0 : tail + 1'b1;
            end
            for (int i = 0; i < OC_ENTRIES; i++) begin
                if (fill[i]) begin
                    slot_collected[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_valid) begin
            slot_src[tail] <= enq_src;
        end
        for (int i = 0; i < OC_ENTRIES; i++) begin
            if (fill[i]) begin
                slot_data[i] <= fill_data[i];
            end
        end
    end

endmodule

// File: src/ldu_pkg.sv
package ldu_pkg;

    // ------------------------------------------------------------
    // sizing

    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

    localparam int FAST_FORWARD_PIPE_COUNT = 4;
    localparam int LOG_FAST_FORWARD_PIPE_COUNT = $clog2(FAST_FORWARD_PIPE_COUNT);

    localparam int LDU_CQ_ENTRIES = 16;
    localparam int LOG_LDU_CQ_ENTRIES = $clog2(LDU_CQ_ENTRIES);

    localparam int VPN_WIDTH = 20;
    localparam int PO_WIDTH = 12;

    // word address bit picking the dcache bank
    localparam int DCACHE_WORD_ADDR_BANK_BIT = 0;

    localparam int IS_OC_BUFFER_SIZE = 2;
    localparam int LOG_IS_OC_BUFFER_SIZE = $clog2(IS_OC_BUFFER_SIZE);

    // buffer depth plus the entry at the head
    localparam int OC_ENTRIES = IS_OC_BUFFER_SIZE + 1;
    localparam int LOG_OC_ENTRIES = $clog2(OC_ENTRIES);

    // ------------------------------------------------------------
    // types

    // bit 1 marks word, bit 0 marks half
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101
    } ldu_op_t;

    typedef struct packed {
        ldu_op_t                        op;
        logic [11:0]                    imm12;
        logic [LOG_LDU_CQ_ENTRIES-1:0]  cq_index;
    } ldu_issue_t;

    typedef struct packed {
        logic                                   is_reg;
        logic                                   is_bus_forward;
        logic                                   is_fast_forward;
        logic [LOG_FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_pipe;
        logic [LOG_PRF_BANK_COUNT-1:0]          bank;
    } operand_src_t;

    typedef struct packed {
        logic                           is_mq;
        logic                           misaligned;
        logic [VPN_WIDTH-1:0]           vpn;
        logic [PO_WIDTH-3:0]            po_word;
        logic [3:0]                     byte_mask;
        logic [LOG_LDU_CQ_ENTRIES-1:0]  cq_index;
    } ldu_req_t;

endpackage

// File: src/ldu_req_sequencer.sv
`timescale 1ns/100ps

module ldu_req_sequencer import ldu_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    input  logic        head_valid,
    input  ldu_issue_t  head_issue,
    input  logic        operand_collected,
    input  logic [31:0] operand_data,

    input  logic        bank0_early_ready,
    input  logic        bank1_early_ready,

    output logic        advance,
    output logic        req_bank0_valid,
    output logic        req_bank1_valid,
    output ldu_req_t    req
);

    typedef enum logic [1:0] {
        IDLE,
        ACTIVE,
        MISALIGNED
    } seq_state_t;

    seq_state_t state;
    seq_state_t next_state;

    ldu_issue_t     cur_issue;
    logic [31:0]    cur_base;
    logic [31:0]    saved_va;

    logic [31:0]    va;
    logic [31:0]    req_va;
    logic           misaligned;
    logic [3:0]     first_mask;
    logic [3:0]     second_mask;
    logic           req_valid;
    logic           accept;

    ldu_addr_gen addr_gen0 (
        .base(cur_base),
        .op(cur_issue.op),
        .imm12(cur_issue.imm12),
        .va(va),
        .misaligned(misaligned),
        .first_mask(first_mask),
        .second_mask(second_mask)
    );

    // ------------------------------------------------------------
    // control

    assign req_valid = (state != IDLE);
    // both banks must be early-ready
    assign accept = req_valid & bank0_early_ready & bank1_early_ready;

    always_comb begin
        advance = 1'b0;
        next_state = state;
        case (state)
            IDLE: begin
                advance = head_valid & operand_collected;
            end
            ACTIVE: begin
                advance = accept & ~misaligned & head_valid & operand_collected;
                if (accept && misaligned) begin
                    next_state = MISALIGNED;
                end
                else if (accept) begin
                    next_state = IDLE;
                end
            end
            default: begin
                advance = accept & head_valid & operand_collected;
                if (accept) begin
                    next_state = IDLE;
                end
            end
        endcase
        if (advance) begin
            next_state = ACTIVE;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    // payload, operand and saved address
    always_ff @(posedge CLK) begin
        if (advance) begin
            cur_issue <= head_issue;
            cur_base <= operand_data;
        end
        if (state == ACTIVE) begin
            saved_va <= va;
        end
    end

    // ------------------------------------------------------------
    // request outputs

    assign req_va = (state == MISALIGNED) ? saved_va + 32'h4 : va;

    assign req.is_mq = (state == MISALIGNED);
    assign req.misaligned = misaligned;
    assign req.vpn = req_va[31:32-VPN_WIDTH];
    assign req.po_word = req_va[PO_WIDTH-1:2];
    assign req.byte_mask = (state == MISALIGNED) ? second_mask : first_mask;
    assign req.cq_index = cur_issue.cq_index;

    assign req_bank0_valid = req_valid & ~req.po_word[DCACHE_WORD_ADDR_BANK_BIT];
    assign req_bank1_valid = req_valid & req.po_word[DCACHE_WORD_ADDR_BANK_BIT];

endmodule
